// File: rtl/ipod_pkg.sv
`default_nettype none

package ipod_pkg;

  // ========================================
  // Data widths
  // ========================================

  // One audio sample
  typedef logic [15:0] sample_t;

  // One flash word holds two samples, low half first
  typedef logic [31:0] flash_word_t;
  typedef logic [22:0] word_addr_t;

  // Bit 0 picks the half, bits 23:1 are the word address
  typedef logic [23:0] sample_idx_t;

  // Sample period in CLK_50M cycles
  typedef logic [15:0] period_t;

  // Active low, segment a in bit 0
  typedef logic [6:0] seg_t;

  // ========================================
  // Playback constants
  // ========================================

  // About 44 kHz from 50 MHz
  localparam period_t default_period = 16'd1136;
  localparam period_t period_step    = 16'd64;
  localparam period_t min_period     = 16'd256;
  localparam period_t max_period     = 16'd4096;

  // Digits on the period display
  localparam int num_digits = 4;

endpackage

`default_nettype wire

// File: rtl/sample_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface sample_req_if;

  // Request side
  logic                   req_valid;
  logic                   req_ready;
  ipod_pkg::word_addr_t   req_addr;

  // Response side with a single-cycle valid pulse
  logic                   rsp_valid;
  ipod_pkg::flash_word_t  rsp_data;

  modport requester (
    output req_valid,
    output req_addr,
    input  req_ready,
    input  rsp_valid,
    input  rsp_data
  );

  modport server (
    input  req_valid,
    input  req_addr,
    output req_ready,
    output rsp_valid,
    output rsp_data
  );

endinterface

`default_nettype wire

// File: rtl/hex_digit_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module hex_digit_decoder (
  input  wire [3:0]        nibble,
  output ipod_pkg::seg_t   seg
);

  // Bits 6..0 are segments g..a, zero lights the segment
  always_comb
  begin
    case (nibble)
      4'h0: seg = 7'h40;
      4'h1: seg = 7'h79;
      4'h2: seg = 7'h24;
      4'h3: seg = 7'h30;
      4'h4: seg = 7'h19;
      4'h5: seg = 7'h12;
      4'h6: seg = 7'h02;
      4'h7: seg = 7'h78;
      4'h8: seg = 7'h00;
      4'h9: seg = 7'h10;
      4'hA: seg = 7'h08;
      4'hB: seg = 7'h03;
      4'hC: seg = 7'h46;
      4'hD: seg = 7'h21;
      4'hE: seg = 7'h06;
      default: seg = 7'h0E;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/speed_control.sv
`timescale 1ns/1ps
`default_nettype none

module speed_control (
  input  wire                CLK_50M,
  input  wire                rst_n,
  input  wire                key_faster_n,
  input  wire                key_slower_n,
  input  wire                key_reset_n,
  output ipod_pkg::period_t  period
);

  // Key bits are 0 faster, 1 slower and 2 reset
  logic [2:0] keys_n;
  logic [2:0] sync_1;
  logic [2:0] sync_2;
  logic [2:0] keys_prev;
  logic [2:0] press;

  assign keys_n = {key_reset_n, key_slower_n, key_faster_n};

  // ========================================
  // Synchronizers and press detection
  // ========================================

  // Idle keys read high
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sync_1    <= 3'b111;
      sync_2    <= 3'b111;
      keys_prev <= 3'b111;
    end
    else
    begin
      sync_1    <= keys_n;
      sync_2    <= sync_1;
      keys_prev <= sync_2;
    end
  end

  // One event on the high-to-low edge only
  assign press = keys_prev & ~sync_2;

  // ========================================
  // Period register
  // ========================================

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      period <= ipod_pkg::default_period;
    end
    else if (press[2])
    begin
      period <= ipod_pkg::default_period;
    end
    else if (press[0])
    begin
      // Shorter period, faster playback
      if (period <= ipod_pkg::min_period + ipod_pkg::period_step)
        period <= ipod_pkg::min_period;
      else
        period <= period - ipod_pkg::period_step;
    end
    else if (press[1])
    begin
      if (period >= ipod_pkg::max_period - ipod_pkg::period_step)
        period <= ipod_pkg::max_period;
      else
        period <= period + ipod_pkg::period_step;
    end
  end

endmodule

`default_nettype wire

// File: rtl/playback_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module playback_sequencer (
  input  wire                   CLK_50M,
  input  wire                   rst_n,
  input  ipod_pkg::period_t     period,
  sample_req_if.requester       req,
  output logic                  sample_valid,
  input  wire                   sample_ready,
  output ipod_pkg::sample_t     sample_data
);

  ipod_pkg::period_t      cycle_cnt;
  ipod_pkg::sample_idx_t  sample_idx;
  logic                   tick;
  logic                   wait_rsp;
  logic                   pending;

  // ========================================
  // Sample-rate divider
  // ========================================

  // Compare with >= so a shorter period never overruns the count
  assign tick = (cycle_cnt >= period - ipod_pkg::period_t'(1));

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      cycle_cnt <= '0;
    else if (tick)
      cycle_cnt <= '0;
    else
      cycle_cnt <= cycle_cnt + ipod_pkg::period_t'(1);
  end

  // ========================================
  // Request issue and index
  // ========================================

  // A tick finding anything in flight is dropped
  assign pending = req.req_valid | wait_rsp | sample_valid;

  // Index only moves on a response, so the address holds during a request
  assign req.req_addr = sample_idx[23:1];

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      req.req_valid <= 1'b0;
      wait_rsp      <= 1'b0;
      sample_valid  <= 1'b0;
      sample_idx    <= '0;
    end
    else
    begin
      if (tick && !pending)
        req.req_valid <= 1'b1;
      else if (req.req_valid && req.req_ready)
      begin
        req.req_valid <= 1'b0;
        wait_rsp      <= 1'b1;
      end

      if (req.rsp_valid)
      begin
        wait_rsp     <= 1'b0;
        sample_valid <= 1'b1;
        sample_idx   <= sample_idx + ipod_pkg::sample_idx_t'(1);
      end
      else if (sample_valid && sample_ready)
        sample_valid <= 1'b0;
    end
  end

  // Low half for an even index
  always_ff @(posedge CLK_50M)
  begin
    if (req.rsp_valid)
      sample_data <= sample_idx[0] ? req.rsp_data[31:16] : req.rsp_data[15:0];
  end

endmodule

`default_nettype wire

// File: rtl/flash_reader.sv
`timescale 1ns/1ps
`default_nettype none

module flash_reader (
  input  wire                     CLK_50M,
  input  wire                     rst_n,
  sample_req_if.server            req,
  output logic                    flash_read,
  output ipod_pkg::word_addr_t    flash_address,
  input  wire                     flash_waitrequest,
  input  ipod_pkg::flash_word_t   flash_readdata,
  input  wire                     flash_readdatavalid
);

  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_wait_data
  } state_t;

  state_t state;

  assign req.req_ready = (state == st_idle);
  assign flash_read    = (state == st_read);

  // ========================================
  // Read FSM
  // ========================================

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state         <= st_idle;
      req.rsp_valid <= 1'b0;
    end
    else
    begin
      req.rsp_valid <= 1'b0;
      case (state)
        st_idle:
          if (req.req_valid)
            state <= st_read;
        // Address and read stay put while the flash stalls
        st_read:
          if (!flash_waitrequest)
            state <= st_wait_data;
        st_wait_data:
          if (flash_readdatavalid)
          begin
            req.rsp_valid <= 1'b1;
            state         <= st_idle;
          end
        default:
          state <= st_idle;
      endcase
    end
  end

  // Address and data holding registers
  always_ff @(posedge CLK_50M)
  begin
    if (state == st_idle && req.req_valid)
      flash_address <= req.req_addr;
    if (state == st_wait_data && flash_readdatavalid)
      req.rsp_data <= flash_readdata;
  end

endmodule

`default_nettype wire

// File: rtl/ipod_top.sv
`timescale 1ns/1ps
`default_nettype none

module ipod_top (
  input  wire                     CLK_50M,
  input  wire                     rst_n,
  input  wire                     key_faster_n,
  input  wire                     key_slower_n,
  input  wire                     key_reset_n,
  output logic                    flash_read,
  output ipod_pkg::word_addr_t    flash_address,
  input  wire                     flash_waitrequest,
  input  ipod_pkg::flash_word_t   flash_readdata,
  input  wire                     flash_readdatavalid,
  output logic                    sample_valid,
  input  wire                     sample_ready,
  output ipod_pkg::sample_t       sample_data,
  output ipod_pkg::seg_t          hex0,
  output ipod_pkg::seg_t          hex1,
  output ipod_pkg::seg_t          hex2,
  output ipod_pkg::seg_t          hex3
);

  ipod_pkg::period_t  period;
  ipod_pkg::seg_t     hex_segs [ipod_pkg::num_digits];

  sample_req_if u_sample_req ();

  speed_control u_speed_control (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .key_faster_n (key_faster_n),
    .key_slower_n (key_slower_n),
    .key_reset_n  (key_reset_n),
    .period       (period)
  );

  playback_sequencer u_playback_sequencer (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .period       (period),
    .req          (u_sample_req.requester),
    .sample_valid (sample_valid),
    .sample_ready (sample_ready),
    .sample_data  (sample_data)
  );

  flash_reader u_flash_reader (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .req                 (u_sample_req.server),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid)
  );

  // ========================================
  // Period display with digit 0 on the low nibble
  // ========================================

  for (genvar i = 0; i < ipod_pkg::num_digits; i++)
  begin : g_digit
    hex_digit_decoder u_hex_digit_decoder (
      .nibble (period[4*i +: 4]),
      .seg    (hex_segs[i])
    );
  end

  assign hex0 = hex_segs[0];
  assign hex1 = hex_segs[1];
  assign hex2 = hex_segs[2];
  assign hex3 = hex_segs[3];

endmodule

`default_nettype wire

// File: test/flash_model.sv
`timescale 1ns/1ps
`default_nettype none

module flash_model (
  input  wire                          CLK_50M,
  input  wire                          flash_read,
  input  wire ipod_pkg::word_addr_t    flash_address,
  output logic                         flash_waitrequest,
  output ipod_pkg::flash_word_t        flash_readdata,
  output logic                         flash_readdatavalid
);

  // Loaded words; all other addresses read a fill pattern
  ipod_pkg::flash_word_t  mem [ipod_pkg::word_addr_t];
  ipod_pkg::word_addr_t   addr_q;
  integer                 seed;
  int                     latency;
  logic                   accept;
  logic                   deliver;

  // Whole address in the low bits, inverted low address bits on top
  function automatic ipod_pkg::flash_word_t read_word(ipod_pkg::word_addr_t addr);
    if (mem.exists(addr))
      return mem[addr];
    return {~addr[8:0], addr};
  endfunction

  initial
  begin
    seed                = 86;
    latency             = 0;
    flash_waitrequest   = 1'b1;
    flash_readdata      = '0;
    flash_readdatavalid = 1'b0;
  end

  // ========================================
  // Read port with random stalls and latency
  // ========================================

  always @(posedge CLK_50M)
  begin
    accept  = flash_read && !flash_waitrequest;
    deliver = 1'b0;
    if (accept)
    begin
      addr_q  = flash_address;
      latency = 1 + int'($unsigned($random(seed)) % 4);
    end
    else if (latency > 0)
    begin
      latency = latency - 1;
      deliver = (latency == 0);
    end
    // Outputs change 2 ns after the edge
    #2;
    flash_readdatavalid = deliver;
    flash_readdata      = deliver ? read_word(addr_q) : '0;
    // One read at a time, random stalls while idle
    flash_waitrequest   = (latency > 0) || ($random(seed) % 3 == 0);
  end

endmodule

`default_nettype wire

// File: test/tb_ipod.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ipod;

  localparam int clk_period_ns  = 20;
  localparam int drive_delay_ns = 2;

  logic                   CLK_50M;
  logic                   rst_n;
  logic                   key_faster_n;
  logic                   key_slower_n;
  logic                   key_reset_n;
  logic                   flash_read;
  ipod_pkg::word_addr_t   flash_address;
  logic                   flash_waitrequest;
  ipod_pkg::flash_word_t  flash_readdata;
  logic                   flash_readdatavalid;
  logic                   sample_valid;
  logic                   sample_ready;
  ipod_pkg::sample_t      sample_data;
  ipod_pkg::seg_t         hex [ipod_pkg::num_digits];

  // Vector contents with commands kept in file order
  ipod_pkg::sample_t      exp_samples [$];
  int                     cmd_tag [$];
  int                     cmd_arg [$];
  int                     cmd_count [$];
  int                     num_samples;
  int                     total_presses;
  bit                     vectors_loaded;

  // Stream and flash monitor state
  integer                 seed;
  int                     samples_checked;
  int                     samples_taken;
  int                     reads_this_sample;
  logic                   hold_pending;
  ipod_pkg::sample_t      held_data;
  ipod_pkg::sample_idx_t  next_idx;

  ipod_top u_ipod_top (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .key_faster_n        (key_faster_n),
    .key_slower_n        (key_slower_n),
    .key_reset_n         (key_reset_n),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .sample_valid        (sample_valid),
    .sample_ready        (sample_ready),
    .sample_data         (sample_data),
    .hex0                (hex[0]),
    .hex1                (hex[1]),
    .hex2                (hex[2]),
    .hex3                (hex[3])
  );

  flash_model u_flash_model (
    .CLK_50M             (CLK_50M),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid)
  );

  always #(clk_period_ns / 2) CLK_50M = ~CLK_50M;

  // ========================================
  // Compare tasks
  // ========================================

  task automatic report_failure();
    $display("Regression failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_sample(string name, ipod_pkg::sample_t expected,
                              ipod_pkg::sample_t actual);
    if (actual !== expected)
    begin
      $display("** Error: %s expected %h, got %h at %0t", name, expected, actual, $time);
      report_failure();
    end
  endtask

  task automatic check_segments(string name, ipod_pkg::seg_t expected,
                                ipod_pkg::seg_t actual);
    if (actual !== expected)
    begin
      $display("** Error: %s expected %h, got %h at %0t", name, expected, actual, $time);
      report_failure();
    end
  endtask

  task automatic check_address(string name, ipod_pkg::word_addr_t expected,
                               ipod_pkg::word_addr_t actual);
    if (actual !== expected)
    begin
      $display("** Error: %s expected %h, got %h at %0t", name, expected, actual, $time);
      report_failure();
    end
  endtask

  // Lit segments per digit with a in bit 0 and zero lighting a segment
  function automatic ipod_pkg::seg_t seg_pattern(logic [3:0] digit);
    string          lit;
    ipod_pkg::seg_t seg;
    int             bit_idx;
    case (digit)
      4'h0: lit = "abcdef";
      4'h1: lit = "bc";
      4'h2: lit = "abdeg";
      4'h3: lit = "abcdg";
      4'h4: lit = "bcfg";
      4'h5: lit = "acdfg";
      4'h6: lit = "acdefg";
      4'h7: lit = "abc";
      4'h8: lit = "abcdefg";
      4'h9: lit = "abcdfg";
      4'hA: lit = "abcefg";
      4'hB: lit = "cdefg";
      4'hC: lit = "adef";
      4'hD: lit = "bcdeg";
      4'hE: lit = "adefg";
      default: lit = "aefg";
    endcase
    seg = '1;
    for (int i = 0; i < lit.len(); i++)
    begin
      bit_idx = lit.getc(i) - "a";
      seg[bit_idx] = 1'b0;
    end
    return seg;
  endfunction

  // Key 0 faster, 1 slower, 2 reset
  function automatic ipod_pkg::period_t next_period(ipod_pkg::period_t p, int key);
    int v;
    v = int'(p);
    case (key)
      0: v = v - int'(ipod_pkg::period_step);
      1: v = v + int'(ipod_pkg::period_step);
      default: v = int'(ipod_pkg::default_period);
    endcase
    if (v < int'(ipod_pkg::min_period))
      v = int'(ipod_pkg::min_period);
    if (v > int'(ipod_pkg::max_period))
      v = int'(ipod_pkg::max_period);
    return ipod_pkg::period_t'(v);
  endfunction

  task automatic check_display(ipod_pkg::period_t p);
    for (int i = 0; i < ipod_pkg::num_digits; i++)
      check_segments($sformatf("hex%0d", i), seg_pattern(p[4*i +: 4]), hex[i]);
  endtask

  // Key held for 4 cycles and display checked 10 cycles after the press
  task automatic press_key(int key);
    @(posedge CLK_50M);
    #(drive_delay_ns);
    key_faster_n = (key != 0);
    key_slower_n = (key != 1);
    key_reset_n  = (key != 2);
    repeat (4) @(posedge CLK_50M);
    #(drive_delay_ns);
    key_faster_n = 1'b1;
    key_slower_n = 1'b1;
    key_reset_n  = 1'b1;
    repeat (6) @(posedge CLK_50M);
    #(drive_delay_ns);
  endtask

  task automatic read_vectors();
    int          fd;
    int          n;
    int          words;
    string       line;
    byte         tag;
    logic [31:0] a;
    logic [31:0] b;
    words = 0;
    fd = $fopen("test/ipod_vectors.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open test/ipod_vectors.txt");
      report_failure();
    end
    while (!$feof(fd))
    begin
      n = $fgets(line, fd);
      // Comments and blank lines skipped
      if (n > 1 && line.getc(0) != "#")
      begin
        tag = line.getc(0);
        a = '0;
        b = '0;
        n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
        case (tag)
          "W":
          begin
            u_flash_model.mem[ipod_pkg::word_addr_t'(words)] = a;
            words++;
          end
          "S": exp_samples.push_back(a[15:0]);
          "P", "K":
          begin
            if (tag == "K" && a > 2)
            begin
              $display("Unknown key code %0d in the vector file", a);
              report_failure();
            end
            cmd_tag.push_back(tag);
            cmd_arg.push_back(a);
            cmd_count.push_back(b);
            if (tag == "K")
              total_presses += b;
          end
          default:
          begin
            $display("Unknown line in the vector file: %s", line);
            report_failure();
          end
        endcase
      end
    end
    $fclose(fd);
    num_samples    = exp_samples.size();
    vectors_loaded = 1'b1;
  endtask

  // ========================================
  // Stream sink and flash monitor
  // ========================================

  always @(posedge CLK_50M)
  begin
    #(drive_delay_ns);
    sample_ready = ($random(seed) % 4) != 0;
  end

  always @(posedge CLK_50M)
  begin
    if (rst_n)
    begin
      // Waiting sample must stay put
      if (hold_pending)
      begin
        if (!sample_valid)
        begin
          $display("sample_valid dropped before the sample was accepted");
          report_failure();
        end
        check_sample("sample_data", held_data, sample_data);
      end
      hold_pending = sample_valid && !sample_ready;
      held_data    = sample_data;

      if (flash_read && !flash_waitrequest)
      begin
        if (sample_valid || reads_this_sample != 0)
        begin
          $display("Flash read accepted while a sample was pending or already read");
          report_failure();
        end
        next_idx = ipod_pkg::sample_idx_t'(samples_taken);
        check_address("flash_address", next_idx[23:1], flash_address);
        reads_this_sample++;
      end

      if (sample_valid && sample_ready)
      begin
        if (samples_checked < num_samples)
        begin
          check_sample("sample_data", exp_samples[samples_checked], sample_data);
          samples_checked++;
        end
        samples_taken++;
        reads_this_sample = 0;
      end
    end
  end

  // One max period per sample with four to spare, plus time for the keys
  initial
  begin
    longint limit_ns;
    wait (vectors_loaded);
    limit_ns = longint'(num_samples + 4) * ipod_pkg::max_period * clk_period_ns
               + longint'(total_presses) * 1000;
    #(limit_ns);
    $display("Timeout: the run did not finish within %0d ns", limit_ns);
    report_failure();
  end

  // ========================================
  // Main sequence
  // ========================================

  initial
  begin
    ipod_pkg::period_t model;
    CLK_50M           = 1'b0;
    rst_n             = 1'b0;
    key_faster_n      = 1'b1;
    key_slower_n      = 1'b1;
    key_reset_n       = 1'b1;
    sample_ready      = 1'b0;
    seed              = 86;
    samples_checked   = 0;
    samples_taken     = 0;
    reads_this_sample = 0;
    hold_pending      = 1'b0;
    total_presses     = 0;
    vectors_loaded    = 1'b0;
    model             = ipod_pkg::default_period;
    read_vectors();

    repeat (4) @(posedge CLK_50M);
    #(drive_delay_ns);
    rst_n = 1'b1;
    check_display(ipod_pkg::default_period);

    wait (samples_checked == num_samples);

    foreach (cmd_tag[i])
    begin
      if (cmd_tag[i] == "P")
        check_display(ipod_pkg::period_t'(cmd_arg[i]));
      else
        repeat (cmd_count[i])
        begin
          model = next_period(model, cmd_arg[i]);
          press_key(cmd_arg[i]);
          check_display(model);
        end
    end

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/ipod_vectors.txt
# W word: flash word, S sample: expected sample, P period: expected period
# K key count: key 0 faster, 1 slower, 2 reset, pressed count times; all values hex
W 8a3f1c20
W 0bad5eed
W 7fff8000
W 1234abcd
S 1c20
S 8a3f
S 5eed
S 0bad
S 8000
S 7fff
S abcd
S 1234
P 0470
K 0 01
P 0430
K 1 02
P 04b0
K 0 14
P 0100
K 1 40
P 1000
K 2 01
P 0470

// File: tb.f
rtl/ipod_pkg.sv
rtl/sample_req_if.sv
rtl/hex_digit_decoder.sv
rtl/speed_control.sv
rtl/playback_sequencer.sv
rtl/flash_reader.sv
rtl/ipod_top.sv
test/flash_model.sv
test/tb_ipod.sv

// File: Bender.yml
package:
  name: ipod_playback

sources:
  - rtl/ipod_pkg.sv
  - rtl/sample_req_if.sv
  - rtl/hex_digit_decoder.sv
  - rtl/speed_control.sv
  - rtl/playback_sequencer.sv
  - rtl/flash_reader.sv
  - rtl/ipod_top.sv
  - target: test
    files:
      - test/flash_model.sv
      - test/tb_ipod.sv
